// File: dv/procChecker.sv
/*
 * Checker for the five-stage core
 * Sequential ISA model run from the program and memory image at reset
 * Bus transfer order, hold stability, halt and err behavior
 */
`timescale 1ns/100ps
`default_nettype none

module procChecker import procPkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire  [dataWidth-1:0] instrAddr,
    input  wire                  cyc,
    input  wire                  stb,
    input  wire                  we,
    input  wire  [dataWidth-1:0] adr,
    input  wire  [dataWidth-1:0] datMosi,
    input  wire                  ack,
    input  wire                  halted,
    input  wire                  err,
    input  logic [dataWidth-1:0] progRom [256],
    input  logic [dataWidth-1:0] memInit [256],
    output int                   mismatches,
    output int                   otherErrors
);

    logic                 expWe   [256];  // Expected transfers in program order
    logic [dataWidth-1:0] expAdr  [256];
    logic [dataWidth-1:0] expData [256];
    int                   expCount;
    int                   expStores;
    logic                 expErr;         // Program holds an illegal opcode
    int                   busIdx;
    int                   storesSeen;
    int                   runNo;
    logic                 open;           // Request waiting for ack
    logic                 openWe;
    logic [dataWidth-1:0] openAdr;
    logic [dataWidth-1:0] openData;
    logic                 prevReset;
    logic                 prevHalted;
    logic                 prevErr;

    initial begin
        mismatches  = 0;
        otherErrors = 0;
        runNo       = 0;
        open        = 1'b0;
        prevReset   = 1'b1;
        prevHalted  = 1'b0;
        prevErr     = 1'b0;
    end

    task automatic reportMismatch(input string what, input logic [dataWidth-1:0] expVal,
                                  input logic [dataWidth-1:0] actVal);
        $display("mismatch run %0d %s: expected %h, actual %h", runNo, what, expVal, actVal);
        mismatches++;
    endtask

    task automatic reportFailure(input string what);
        $display("run %0d: %s", runNo, what);
        otherErrors++;
    endtask

    // One instruction at a time without pipeline
    task automatic runModel();
        logic [dataWidth-1:0] regs [8];
        logic [dataWidth-1:0] mem [256];
        logic [dataWidth-1:0] word;
        logic [dataWidth-1:0] imm5;
        logic [dataWidth-1:0] addr;
        logic [2:0]           rs;
        logic [2:0]           rt;
        logic [2:0]           rd;
        int                   pc;
        bit                   running;
        for (int i = 0; i < 256; i++) mem[i] = memInit[i];
        for (int i = 0; i < 8; i++) regs[i] = '0;
        expCount  = 0;
        expStores = 0;
        expErr    = 1'b0;
        pc        = 0;
        running   = 1'b1;
        while (running && pc < 256) begin
            word = progRom[pc];
            pc++;
            rs   = word[10:8];
            rt   = word[7:5];
            rd   = word[4:2];
            imm5 = {{11{word[4]}}, word[4:0]};
            addr = regs[rs] + imm5;          // ADDI sum or LD/ST address
            case (word[15:11])
                opNop: ;
                opHalt: running = 1'b0;
                opAlu: begin
                    case (word[1:0])
                        fnAdd:   regs[rd] = regs[rs] + regs[rt];
                        fnSub:   regs[rd] = regs[rs] - regs[rt];
                        fnAnd:   regs[rd] = regs[rs] & regs[rt];
                        default: regs[rd] = regs[rs] ^ regs[rt];
                    endcase
                end
                opAddi: regs[rt] = addr;
                opLbi:  regs[rs] = {{8{word[7]}}, word[7:0]};
                opLd: begin
                    expWe[expCount]  = 1'b0;
                    expAdr[expCount] = addr;
                    expCount++;
                    regs[rt] = mem[addr[7:0]];
                end
                opSt: begin
                    expWe[expCount]   = 1'b1;
                    expAdr[expCount]  = addr;
                    expData[expCount] = regs[rt];
                    expCount++;
                    expStores++;
                    mem[addr[7:0]] = regs[rt];
                end
                default: expErr = 1'b1;  // Behaves as NOP
            endcase
        end
    endtask

    task automatic checkTransfer();
        if (busIdx >= expCount) begin
            reportFailure("bus transfer after the last one in the program");
        end else if (we !== expWe[busIdx]) begin
            reportMismatch("transfer write enable", expWe[busIdx], we);
        end else if (we) begin
            if (adr !== expAdr[busIdx]) reportMismatch("store address", expAdr[busIdx], adr);
            if (datMosi !== expData[busIdx]) begin
                reportMismatch("store data", expData[busIdx], datMosi);
            end
        end else if (adr !== expAdr[busIdx]) begin
            reportMismatch("load address", expAdr[busIdx], adr);
        end
        if (we) storesSeen++;
        busIdx++;
    endtask

    always @(posedge clk) begin
        if (reset) begin
            runModel();  // Arrays are steady while reset is high
            busIdx     = 0;
            storesSeen = 0;
            open       = 1'b0;
        end else begin
            if (prevReset) begin
                runNo++;
                if (halted || err || cyc) reportFailure("reset left halted, err or cyc high");
                if (instrAddr !== '0) begin
                    reportMismatch("fetch address after reset", '0, instrAddr);
                end
            end
            // Request must stay put until ack
            if (open && !(cyc && stb)) begin
                reportFailure("bus request dropped before ack");
                open = 1'b0;
            end else if (open) begin
                if (adr !== openAdr) reportMismatch("held address", openAdr, adr);
                if (we !== openWe) reportMismatch("held write enable", openWe, we);
                if (openWe && datMosi !== openData) begin
                    reportMismatch("held store data", openData, datMosi);
                end
            end
            if (cyc && stb) begin
                if (halted) reportFailure("bus cycle after halted");
                if (!open) begin
                    open     = 1'b1;
                    openWe   = we;
                    openAdr  = adr;
                    openData = datMosi;
                end
                if (ack) begin
                    checkTransfer();
                    open = 1'b0;
                end
            end
            if (!prevReset && prevHalted && !halted) reportFailure("halted fell before reset");
            if (!prevReset && prevErr && !err) reportFailure("err fell before reset");
            if (err && !prevErr && !expErr) reportFailure("err raised without an illegal opcode");
            // End-of-run state once halted rises
            if (halted && !prevHalted) begin
                if (busIdx != expCount) reportMismatch("transfer count", expCount, busIdx);
                if (storesSeen != expStores) reportMismatch("store count", expStores, storesSeen);
                if (err !== expErr) reportMismatch("err at halt", expErr, err);
            end
        end
        prevReset  = reset;
        prevHalted = halted;
        prevErr    = err;
    end

endmodule

`default_nettype wire

// File: dv/procTb.sv
/*
 * Testbench top for the five-stage core
 * Clock, reset, random programs and instruction ROM
 * Wishbone slave memory with random ack latency, DUT and checker
 */
`timescale 1ns/100ps
`default_nettype none

module procTb import procPkg::*; ();

    logic                 clk;
    logic                 reset;
    logic [dataWidth-1:0] instrAddr;
    logic [dataWidth-1:0] instr;
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [dataWidth-1:0] adr;
    logic [dataWidth-1:0] datMosi;
    logic                 ack;
    logic [dataWidth-1:0] datMiso;
    logic                 halted;
    logic                 err;

    logic [dataWidth-1:0] rom [256];      // Program indexed by low PC bits
    logic [dataWidth-1:0] dataMem [256];  // Slave memory by low address bits
    integer               seed;
    int                   timeouts;
    int                   mismatches;
    int                   otherErrors;
    logic                 busy;           // Request seen and not yet acked
    int                   waitLeft;

    always #10 clk = ~clk;

    assign instr = rom[instrAddr[7:0]];  // Same-cycle fetch answer

    proc proc_inst (
        .clk(clk), .reset(reset), .instrAddr(instrAddr), .instr(instr),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datMosi(datMosi),
        .ack(ack), .datMiso(datMiso), .halted(halted), .err(err)
    );

    procChecker procCheckerInst (
        .clk(clk), .reset(reset), .instrAddr(instrAddr),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .datMosi(datMosi), .ack(ack), .halted(halted), .err(err),
        .progRom(rom), .memInit(dataMem),
        .mismatches(mismatches), .otherErrors(otherErrors)
    );

    // Slave answers 1 ns after the edge with 0 to 3 wait cycles
    always @(posedge clk) begin
        #1;
        ack = 1'b0;
        if (reset) begin
            busy = 1'b0;
        end else if (cyc && stb) begin
            if (!busy) begin
                busy     = 1'b1;
                waitLeft = $unsigned($random(seed)) % 4;
            end else begin
                waitLeft = waitLeft - 1;
            end
            if (waitLeft == 0) begin
                ack  = 1'b1;
                busy = 1'b0;
                if (we) dataMem[adr[7:0]] = datMosi;
                else datMiso = dataMem[adr[7:0]];
            end
        end
    end

    // Mostly r0..r3 so dependencies are dense
    task automatic pickReg(output logic [2:0] idx);
        logic [31:0] rnd;
        rnd = $random(seed);
        idx = rnd[3] ? rnd[2:0] : {1'b0, rnd[1:0]};
    endtask

    task automatic randomInstr(output logic [dataWidth-1:0] word);
        logic [31:0] rnd;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [2:0]  rc;
        pickReg(ra);
        pickReg(rb);
        pickReg(rc);
        rnd = $random(seed);
        case (rnd[2:0])
            3'd0, 3'd1: word = {opAlu, ra, rb, rc, rnd[4:3]};
            3'd2:       word = {opAddi, ra, rb, rnd[12:8]};
            3'd3:       word = {opLbi, ra, rnd[15:8]};
            3'd4, 3'd5: word = {opLd, ra, rb, rnd[12:8]};
            default:    word = {opSt, ra, rb, rnd[12:8]};
        endcase
    endtask

    task automatic makeProgram(input bit withIllegal);
        int                   n;
        logic [2:0]           base;
        logic [31:0]          rnd;
        logic [dataWidth-1:0] word;
        n = 0;
        for (int k = 0; k < 48; k++) begin
            randomInstr(word);
            rom[n] = word;
            n++;
        end
        rnd = $random(seed);
        if (withIllegal) rom[24] = {5'b11111, rnd[10:0]};  // Unused opcode
        for (int r = 0; r < 8; r++) begin  // Dump every register
            pickReg(base);
            rnd    = $random(seed);
            rom[n] = {opSt, base, 3'(r), rnd[4:0]};
            n++;
        end
        rom[n] = {opHalt, 11'b0};
        n++;
        while (n < 256) begin  // Live code past HALT that must never issue
            randomInstr(word);
            rom[n] = word;
            n++;
        end
    endtask

    task automatic fillMemory();
        for (int i = 0; i < 256; i++) dataMem[i] = $random(seed);
    endtask

    task automatic waitHalt();
        int cycles;
        cycles = 0;
        while (!halted && cycles < 2000) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!halted) begin
            $display("timeout waiting for halt");
            timeouts++;
        end
    endtask

    // Arrays change only while reset is high
    task automatic runProgram(input bit withIllegal);
        #1;
        reset = 1'b1;
        fillMemory();
        makeProgram(withIllegal);
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        waitHalt();
        repeat (4) @(posedge clk);  // Room for stray bus cycles
    endtask

    initial begin
        seed     = 92064;
        clk      = 1'b0;
        reset    = 1'b1;
        ack      = 1'b0;
        datMiso  = '0;
        busy     = 1'b0;
        waitLeft = 0;
        timeouts = 0;
        for (int i = 0; i < 256; i++) rom[i] = '0;
        runProgram(1'b0);   // Clean random program
        runProgram(1'b1);   // Same again with one illegal opcode
        runProgram(1'b0);   // Reset must clear the sticky err
        $display("Error counts: %0d mismatches, %0d other failures, %0d timeouts",
                 mismatches, otherErrors, timeouts);
        if (mismatches + otherErrors + timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/decode.sv
/*
 * Decode stage
 * Field split, immediate extension, control, register file with write bypass
 * RAW hazard stall, sticky illegal-opcode flag, halt detection
 */
`timescale 1ns/100ps
`default_nettype none

module decode import procPkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            hold,       // Memory freeze
    input  wire            fetchPayloadT fetched,
    input  wire            memPayloadT wbIn,          // Write port from memWb
    input  wire            decodePayloadT idExOut,    // For hazard compare
    input  wire            executePayloadT exMemOut,  // For hazard compare
    output decodePayloadT  decoded,
    output logic           stall,
    output logic           haltSeen,
    output logic           err
);

    logic [dataWidth-1:0]    regs [2**regAddrWidth];
    logic [4:0]              opcode;
    logic [1:0]              funct;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [dataWidth-1:0]    imm5Ext;
    logic [dataWidth-1:0]    imm8Ext;
    logic [dataWidth-1:0]    rsRead;
    logic [dataWidth-1:0]    rtRead;
    logic                    usesRs;
    logic                    usesRt;
    logic                    illegal;
    logic                    rsHazard;
    logic                    rtHazard;
    decodePayloadT           ctl;

    assign opcode  = fetched.instr[15:11];
    assign rs      = fetched.instr[10:8];
    assign rt      = fetched.instr[7:5];
    assign rd      = fetched.instr[4:2];
    assign funct   = fetched.instr[1:0];
    assign imm5Ext = {{(dataWidth-5){fetched.instr[4]}}, fetched.instr[4:0]};
    assign imm8Ext = {{(dataWidth-8){fetched.instr[7]}}, fetched.instr[7:0]};

    // Register file, written at the end of the WB cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**regAddrWidth; i++) begin
                regs[i] <= '0;
            end
        end else if (wbIn.regWrite) begin
            regs[wbIn.dest] <= wbIn.value;
        end
    end

    // Same-cycle write shows through on read
    assign rsRead = (wbIn.regWrite && wbIn.dest == rs) ? wbIn.value : regs[rs];
    assign rtRead = (wbIn.regWrite && wbIn.dest == rt) ? wbIn.value : regs[rt];

    always_comb begin
        ctl       = '0;
        usesRs    = 1'b0;
        usesRt    = 1'b0;
        illegal   = 1'b0;
        ctl.rsVal = rsRead;
        ctl.rtVal = rtRead;
        ctl.imm   = imm5Ext;
        case (opcode)
            opNop: ;
            opHalt: ctl.halt = 1'b1;
            opAlu: begin
                usesRs       = 1'b1;
                usesRt       = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.dest     = rd;
                case (funct)
                    fnAdd:   ctl.aluOp = aluAdd;
                    fnSub:   ctl.aluOp = aluSub;
                    fnXor:   ctl.aluOp = aluXor;
                    default: ctl.aluOp = aluAnd;  // fnAnd
                endcase
            end
            opAddi: begin
                usesRs       = 1'b1;
                ctl.useImm   = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.dest     = rt;
            end
            opLbi: begin
                ctl.rsVal    = '0;        // Zero plus immediate in execute
                ctl.imm      = imm8Ext;
                ctl.useImm   = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.dest     = rs;        // rs field names the target
            end
            opLd: begin
                usesRs       = 1'b1;
                ctl.useImm   = 1'b1;
                ctl.memRead  = 1'b1;
                ctl.regWrite = 1'b1;
                ctl.dest     = rt;
            end
            opSt: begin
                usesRs        = 1'b1;
                usesRt        = 1'b1;     // Store data
                ctl.useImm    = 1'b1;
                ctl.memWrite  = 1'b1;
            end
            default: illegal = 1'b1;      // Control stays NOP
        endcase
    end

    // Older writers still in execute or memory
    assign rsHazard = usesRs && ((idExOut.regWrite && idExOut.dest == rs) ||
                                 (exMemOut.regWrite && exMemOut.dest == rs));
    assign rtHazard = usesRt && ((idExOut.regWrite && idExOut.dest == rt) ||
                                 (exMemOut.regWrite && exMemOut.dest == rt));
    assign stall    = !haltSeen && (rsHazard || rtHazard);

    // Everything after HALT issues as NOP
    assign decoded = haltSeen ? decodePayloadT'('0) : ctl;

    always_ff @(posedge clk) begin
        if (reset) begin
            haltSeen <= 1'b0;
            err      <= 1'b0;
        end else begin
            if (decoded.halt && !stall && !hold) haltSeen <= 1'b1;  // Halt issued
            if (illegal && !haltSeen) err <= 1'b1;                   // Sticky
        end
    end

endmodule

`default_nettype wire

// File: source/execute.sv
/*
 * Execute stage
 * Second-operand select, ALU, address computation
 */
`timescale 1ns/100ps
`default_nettype none

module execute import procPkg::*; (
    input  wire            decodePayloadT decoded,
    output executePayloadT result
);

    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluOut;

    // LBI arrives with opA zeroed, so the immediate passes through
    assign opA = decoded.rsVal;

    // Immediate for ADDI, LBI and LD/ST offsets
    assign opB = decoded.useImm ? decoded.imm : decoded.rtVal;

    always_comb begin
        case (decoded.aluOp)
            aluAdd:  aluOut = opA + opB;   // Also base plus offset
            aluSub:  aluOut = opA - opB;
            aluXor:  aluOut = opA ^ opB;
            default: aluOut = opA & opB;   // aluAnd
        endcase
    end

    // Control and store data ride along
    always_comb begin
        result.aluResult = aluOut;
        result.storeData = decoded.rtVal;
        result.memRead   = decoded.memRead;
        result.memWrite  = decoded.memWrite;
        result.regWrite  = decoded.regWrite;
        result.dest      = decoded.dest;
        result.halt      = decoded.halt;
    end

endmodule

`default_nettype wire

// File: source/fetch.sv
/*
 * Fetch stage
 * Program counter, fetch address and the fetch payload
 */
`timescale 1ns/100ps
`default_nettype none

module fetch import procPkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  hold,       // Stall, freeze or halt seen
    output logic [dataWidth-1:0] instrAddr,
    input  wire  [dataWidth-1:0] instr,      // Answered in the same cycle
    output fetchPayloadT         payload
);

    logic [dataWidth-1:0] pc;

    // Word-addressed PC, one step per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else if (!hold) begin
            pc <= pc + dataWidth'(1);
        end
    end

    assign instrAddr = pc;

    always_comb begin
        payload.instr = instr;  // Raw word, decode splits it
        payload.pc    = pc;
    end

endmodule

`default_nettype wire

// File: source/memStage.sv
/*
 * Memory stage
 * Wishbone classic master for LD/ST, freeze request, result select
 */
`timescale 1ns/100ps
`default_nettype none

module memStage import procPkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  executePayloadT executed,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output logic [dataWidth-1:0] adr,
    output logic [dataWidth-1:0] datMosi,
    input  wire                  ack,
    input  wire  [dataWidth-1:0] datMiso,
    output memPayloadT           result,
    output logic                 freeze
);

    logic                 access;    // LD or ST in this stage
    logic                 pending;   // Bus cycle opened in an earlier cycle
    logic                 done;      // Late ack taken, instruction still here
    logic [dataWidth-1:0] loadData;  // Word from a late ack

    assign access  = executed.memRead || executed.memWrite;
    assign cyc     = access && !done;
    assign stb     = cyc;
    assign we      = cyc && executed.memWrite;
    assign adr     = executed.aluResult;  // Steady while exMem is frozen
    assign datMosi = executed.storeData;

    // Zero-wait ack needs no freeze, a late one freezes through the ack cycle
    assign freeze = cyc && (pending || !ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            done    <= 1'b0;
        end else begin
            if (cyc) pending <= !ack;
            if (cyc && ack && pending) begin
                done <= 1'b1;
            end else if (!freeze) begin
                done <= 1'b0;                  // Pipeline moves on
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cyc && ack) loadData <= datMiso;
    end

    always_comb begin
        if (executed.memRead) begin
            result.value = done ? loadData : datMiso;
        end else begin
            result.value = executed.aluResult;
        end
        result.regWrite = executed.regWrite;
        result.dest     = executed.dest;
        result.halt     = executed.halt;
    end

endmodule

`default_nettype wire

// File: source/pipeReg.sv
/*
 * Stage register for any payload type
 * Freeze by hold, no-op insertion by bubble
 */
`timescale 1ns/100ps
`default_nettype none

module pipeReg #(
    parameter type payloadT = logic [15:0]
) (
    input  wire     clk,
    input  wire     reset,
    input  wire     hold,    // Keep current contents
    input  wire     bubble,  // Load a no-op
    input  wire     payloadT d,
    output payloadT q
);

    // Hold wins over bubble so a frozen stage keeps its instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;        // All-zero payload is a no-op
        end else if (hold) begin
            q <= q;
        end else if (bubble) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: source/proc.sv
/*
 * Top level of the five-stage core
 * Stage and pipeline register wiring, hold and bubble control, halted flag
 */
`timescale 1ns/100ps
`default_nettype none

module proc import procPkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    output logic [dataWidth-1:0] instrAddr,   // Fetch port
    input  wire  [dataWidth-1:0] instr,
    output logic                 cyc,         // Wishbone master
    output logic                 stb,
    output logic                 we,
    output logic [dataWidth-1:0] adr,
    output logic [dataWidth-1:0] datMosi,
    input  wire                  ack,
    input  wire  [dataWidth-1:0] datMiso,
    output logic                 halted,
    output logic                 err
);

    fetchPayloadT   fetchOut;
    fetchPayloadT   ifIdQ;
    decodePayloadT  decodeOut;
    decodePayloadT  idExQ;
    executePayloadT executeOut;
    executePayloadT exMemQ;
    memPayloadT     memOut;
    memPayloadT     memWbQ;
    logic           stall;
    logic           freeze;
    logic           haltSeen;
    logic           fetchHold;

    assign fetchHold = stall || freeze || haltSeen;

    fetch fetch_inst (
        .clk(clk), .reset(reset), .hold(fetchHold),
        .instrAddr(instrAddr), .instr(instr), .payload(fetchOut)
    );

    // Stays empty once HALT has issued
    pipeReg #(.payloadT(fetchPayloadT)) ifId (
        .clk(clk), .reset(reset), .hold(stall || freeze), .bubble(haltSeen),
        .d(fetchOut), .q(ifIdQ)
    );

    decode decode_inst (
        .clk(clk), .reset(reset), .hold(freeze),
        .fetched(ifIdQ), .wbIn(memWbQ),
        .idExOut(idExQ), .exMemOut(exMemQ),
        .decoded(decodeOut), .stall(stall), .haltSeen(haltSeen), .err(err)
    );

    // Bubble behind a stalled instruction
    pipeReg #(.payloadT(decodePayloadT)) idEx (
        .clk(clk), .reset(reset), .hold(freeze), .bubble(stall),
        .d(decodeOut), .q(idExQ)
    );

    execute execute_inst (
        .decoded(idExQ), .result(executeOut)
    );

    pipeReg #(.payloadT(executePayloadT)) exMem (
        .clk(clk), .reset(reset), .hold(freeze), .bubble(1'b0),
        .d(executeOut), .q(exMemQ)
    );

    memStage memStage_inst (
        .clk(clk), .reset(reset), .executed(exMemQ),
        .cyc(cyc), .stb(stb), .we(we), .adr(adr), .datMosi(datMosi),
        .ack(ack), .datMiso(datMiso),
        .result(memOut), .freeze(freeze)
    );

    // Output feeds the register write port in decode
    pipeReg #(.payloadT(memPayloadT)) memWb (
        .clk(clk), .reset(reset), .hold(freeze), .bubble(1'b0),
        .d(memOut), .q(memWbQ)
    );

    // Rises as the halt payload loads into memWb
    always_ff @(posedge clk) begin
        if (reset) begin
            halted <= 1'b0;
        end else if (memOut.halt && !freeze) begin
            halted <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/procPkg.sv
/*
 * Shared definitions for the 16-bit five-stage core
 * Data and register index widths, opcode and funct codes
 * ALU operation type and the four stage payload structs
 */
`default_nettype none

package procPkg;

    localparam int dataWidth    = 16;  // Data and address width
    localparam int regAddrWidth = 3;   // 8 registers

    // Opcodes in instr[15:11], all-zero word is a NOP bubble
    localparam logic [4:0] opNop  = 5'b00000;
    localparam logic [4:0] opHalt = 5'b00001;
    localparam logic [4:0] opAlu  = 5'b11011;  // rd = rs op rt
    localparam logic [4:0] opAddi = 5'b01000;  // rt = rs + imm5
    localparam logic [4:0] opLbi  = 5'b11000;  // rs = imm8
    localparam logic [4:0] opLd   = 5'b10001;  // rt = mem[rs + imm5]
    localparam logic [4:0] opSt   = 5'b10000;  // mem[rs + imm5] = rt

    // Funct codes in instr[1:0] of the ALU group
    localparam logic [1:0] fnAdd = 2'b00;
    localparam logic [1:0] fnSub = 2'b01;  // rs - rt
    localparam logic [1:0] fnXor = 2'b10;
    localparam logic [1:0] fnAnd = 2'b11;

    typedef enum logic [1:0] {
        aluAdd = 2'b00,
        aluSub = 2'b01,
        aluXor = 2'b10,
        aluAnd = 2'b11
    } aluOpT;

    // Instruction layout
    //   [15:11] opcode  [10:8] rs  [7:5] rt  [4:2] rd  [1:0] funct
    //   imm5 = [4:0], imm8 = [7:0], both sign-extended
    typedef struct packed {
        logic [dataWidth-1:0] instr;
        logic [dataWidth-1:0] pc;
    } fetchPayloadT;

    typedef struct packed {
        logic [dataWidth-1:0]    rsVal;     // Zero for LBI
        logic [dataWidth-1:0]    rtVal;     // Also store data
        logic [dataWidth-1:0]    imm;       // Extended imm5 or imm8
        aluOpT                   aluOp;
        logic                    useImm;    // Immediate as second operand
        logic                    memRead;
        logic                    memWrite;
        logic                    regWrite;
        logic [regAddrWidth-1:0] dest;
        logic                    halt;
    } decodePayloadT;

    typedef struct packed {
        logic [dataWidth-1:0]    aluResult; // ALU value or memory address
        logic [dataWidth-1:0]    storeData;
        logic                    memRead;
        logic                    memWrite;
        logic                    regWrite;
        logic [regAddrWidth-1:0] dest;
        logic                    halt;
    } executePayloadT;

    typedef struct packed {
        logic [dataWidth-1:0]    value;     // Loaded word or ALU result
        logic                    regWrite;
        logic [regAddrWidth-1:0] dest;
        logic                    halt;
    } memPayloadT;

endpackage

`default_nettype wire

// File: src.f
source/procPkg.sv
source/fetch.sv
source/pipeReg.sv
source/decode.sv
source/execute.sv
source/memStage.sv
source/proc.sv
dv/procChecker.sv
dv/procTb.sv
